// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the STA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f tb.f --top-module tb_sta -o tb_sta_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out="$(./obj_dir/tb_sta_sim)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qF 'All tests passed!' <<< "$sim_out"; then
	exit 0
fi
exit 1

// ==== sta_ctrl.sv ====
// --------------------
// STA phase controller
// Idle, load, calculate and output sequencing
// --------------------
`timescale 1ns/1ps

module sta_ctrl (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid_i,
	input  logic     done_i,
	sta_node_if.ctrl nif
);

	sta_pkg::phase_e phase_q;
	sta_pkg::phase_e phase_d;
	logic [4:0]      cnt_q;
	logic            last_load;
	logic            last_calc;

	assign last_load = (cnt_q == 5'(sta_pkg::N_EDGES - 1));
	assign last_calc = (cnt_q == 5'(sta_pkg::CALC_CYCLES - 1));

	always_comb begin
		phase_d = phase_q;
		case (phase_q)
			sta_pkg::PH_IDLE: begin
				if (in_valid_i) begin
					phase_d = sta_pkg::PH_LOAD;
				end
			end
			sta_pkg::PH_LOAD: begin
				if (last_load) begin
					phase_d = sta_pkg::PH_CALC;
				end
			end
			sta_pkg::PH_CALC: begin
				if (last_calc) begin
					phase_d = sta_pkg::PH_OUT;
				end
			end
			default: begin
				if (done_i) begin  // Path reached the primary input
					phase_d = sta_pkg::PH_IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_q <= sta_pkg::PH_IDLE;
			cnt_q   <= '0;
		end else begin
			phase_q <= phase_d;
			if (phase_d != phase_q) begin
				cnt_q <= '0;  // Restart count on every phase change
			end else if (phase_q == sta_pkg::PH_LOAD || phase_q == sta_pkg::PH_CALC) begin
				cnt_q <= cnt_q + 5'd1;
			end
		end
	end

	assign nif.phase = phase_q;

endmodule

// ==== sta_graph.sv ====
// --------------------
// STA graph store
// Delays, adjacency matrix and ready-node selection
// One node visited per calculate cycle
// --------------------
`timescale 1ns/1ps

module sta_graph (
	input  logic            clk,
	input  logic            rst_n,
	input  sta_pkg::delay_t delay_i,
	input  sta_pkg::node_t  source_i,
	input  sta_pkg::node_t  destination_i,
	sta_node_if.graph       nif
);

	localparam int N = sta_pkg::N_NODES;

	sta_pkg::node_mask_t adj_q [N];  // Row u holds the fan-out of node u
	sta_pkg::delay_t     delay_q [N];
	sta_pkg::node_mask_t visited_q;
	logic [4:0]          ld_ptr_q;

	sta_pkg::delay_t     ld_delay_q;
	sta_pkg::node_t      ld_src_q;
	sta_pkg::node_t      ld_dst_q;
	logic                edge_ok;

	sta_pkg::node_mask_t has_fanin;
	sta_pkg::node_mask_t ready;
	sta_pkg::node_t      sel;

	// --------------------
	// Load path
	// --------------------
	// Drop self-loops, edges into the input and edges out of the output
	assign edge_ok = (ld_src_q != ld_dst_q) &&
	                 (ld_dst_q != sta_pkg::SRC_NODE) &&
	                 (ld_src_q != sta_pkg::SINK_NODE);

	always_ff @(posedge clk) begin
		ld_delay_q <= delay_i;  // Load beat lines up with the first LOAD cycle
		ld_src_q   <= source_i;
		ld_dst_q   <= destination_i;
		if (nif.phase == sta_pkg::PH_IDLE) begin
			for (int v = 0; v < N; v++) begin
				delay_q[v] <= '0;
			end
		end else if (nif.phase == sta_pkg::PH_LOAD && !ld_ptr_q[4]) begin
			delay_q[ld_ptr_q[3:0]] <= ld_delay_q;  // First 16 beats only
		end
	end

	// --------------------
	// Ready-node pick
	// --------------------
	always_comb begin
		for (int v = 0; v < N; v++) begin
			has_fanin[v] = 1'b0;
			for (int u = 0; u < N; u++) begin
				has_fanin[v] = has_fanin[v] | adj_q[u][v];
			end
		end
	end

	assign ready = ~visited_q & ~has_fanin;

	always_comb begin
		sel = sta_pkg::node_t'(N - 1);  // Fallback when nothing is ready
		for (int v = N - 2; v >= 0; v--) begin
			if (ready[v]) begin
				sel = sta_pkg::node_t'(v);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int u = 0; u < N; u++) begin
				adj_q[u] <= '0;
			end
			visited_q <= '0;
			ld_ptr_q  <= '0;
		end else begin
			case (nif.phase)
				sta_pkg::PH_IDLE: begin
					for (int u = 0; u < N; u++) begin
						adj_q[u] <= '0;
					end
					visited_q <= '0;
					ld_ptr_q  <= '0;
				end
				sta_pkg::PH_LOAD: begin
					ld_ptr_q <= ld_ptr_q + 5'd1;
					if (edge_ok) begin
						adj_q[ld_src_q][ld_dst_q] <= 1'b1;
					end
				end
				sta_pkg::PH_CALC: begin
					adj_q[sel]     <= '0;  // Releases its successors
					visited_q[sel] <= 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

	assign nif.cur_node  = sel;
	assign nif.succ_mask = adj_q[sel];
	assign nif.delays    = delay_q;

endmodule

// ==== sta_node_if.sv ====
// --------------------
// Node bus between graph store and relaxation unit
// Carries visited node, its fan-out row and the gate delays
// --------------------
`timescale 1ns/1ps

interface sta_node_if;

	sta_pkg::node_t      cur_node;
	sta_pkg::node_mask_t succ_mask;
	sta_pkg::delay_t     delays [sta_pkg::N_NODES];
	sta_pkg::phase_e     phase;

	modport ctrl  (output phase);

	modport graph (output cur_node, output succ_mask, output delays,
	               input  phase);

	modport relax (input cur_node, input succ_mask, input delays,
	               input phase);

endinterface

// ==== sta_pkg.sv ====
// --------------------
// STA package
// Shared sizes, node and cost types, phase encoding
// --------------------
package sta_pkg;

	// Netlist sizes
	localparam int N_NODES     = 16;
	localparam int N_EDGES     = 32;
	localparam int CALC_CYCLES = 16;

	// --------------------
	// Types
	// --------------------
	typedef logic [$clog2(N_NODES)-1:0] node_t;
	typedef logic [3:0]                 delay_t;
	typedef logic [7:0]                 cost_t;   // Worst path of 16 x 15 fits
	typedef logic [N_NODES-1:0]         node_mask_t;

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_LOAD,
		PH_CALC,
		PH_OUT
	} phase_e;

	// Fixed netlist terminals
	localparam node_t SRC_NODE  = 4'd1;  // Primary input
	localparam node_t SINK_NODE = 4'd0;  // Primary output

endpackage

// ==== sta_relax.sv ====
// --------------------
// STA relaxation unit
// Arrival-time and predecessor tables
// Max-plus update on the fan-out of the visited node
// --------------------
`timescale 1ns/1ps

module sta_relax (
	input  logic           clk,
	input  sta_pkg::node_t rd_node_i,
	output sta_pkg::node_t rd_pred_o,
	output sta_pkg::cost_t sink_cost_o,
	sta_node_if.relax      nif
);

	localparam int N = sta_pkg::N_NODES;

	sta_pkg::cost_t      arr_q [N];
	sta_pkg::node_t      pred_q [N];
	sta_pkg::cost_t      cur_cost;
	sta_pkg::cost_t      cand [N];
	sta_pkg::node_mask_t upd;

	assign cur_cost = arr_q[nif.cur_node];

	// --------------------
	// Candidate arrival per successor
	// --------------------
	always_comb begin
		for (int v = 0; v < N; v++) begin
			cand[v] = cur_cost + sta_pkg::cost_t'(nif.delays[v]);
			// Ties go to the later-visited predecessor
			upd[v]  = nif.succ_mask[v] && (cand[v] >= arr_q[v]) &&
			          (v != int'(sta_pkg::SRC_NODE));
		end
	end

	always_ff @(posedge clk) begin
		case (nif.phase)
			sta_pkg::PH_LOAD: begin
				for (int v = 0; v < N; v++) begin
					arr_q[v]  <= '0;
					pred_q[v] <= '0;
				end
			end
			sta_pkg::PH_CALC: begin
				for (int v = 0; v < N; v++) begin
					if (upd[v]) begin
						arr_q[v]  <= cand[v];
						pred_q[v] <= nif.cur_node;
					end
				end
			end
			default: begin
			end
		endcase
		// Input node always starts at its own gate delay
		arr_q[sta_pkg::SRC_NODE] <= sta_pkg::cost_t'(nif.delays[sta_pkg::SRC_NODE]);
	end

	assign rd_pred_o   = pred_q[rd_node_i];
	assign sink_cost_o = arr_q[sta_pkg::SINK_NODE];

endmodule

// ==== sta_top.sv ====
// --------------------
// STA top level
// Critical path of a 16-node netlist loaded as 32 edges
// --------------------
`timescale 1ns/1ps

module sta_top (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_valid_i,
	input  sta_pkg::delay_t delay_i,
	input  sta_pkg::node_t  source_i,
	input  sta_pkg::node_t  destination_i,
	output logic            out_valid_o,
	output sta_pkg::cost_t  worst_delay_o,
	output sta_pkg::node_t  path_o
);

	logic           done;
	sta_pkg::node_t rd_node;
	sta_pkg::node_t rd_pred;
	sta_pkg::cost_t sink_cost;

	sta_node_if node_if ();

	sta_ctrl u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid_i (in_valid_i),
		.done_i     (done),
		.nif        (node_if.ctrl)
	);

	sta_graph u_graph (
		.clk           (clk),
		.rst_n         (rst_n),
		.delay_i       (delay_i),
		.source_i      (source_i),
		.destination_i (destination_i),
		.nif           (node_if.graph)
	);

	sta_relax u_relax (
		.clk         (clk),
		.rd_node_i   (rd_node),
		.rd_pred_o   (rd_pred),
		.sink_cost_o (sink_cost),
		.nif         (node_if.relax)
	);

	// Backtrace sees only the phase
	sta_trace u_trace (
		.clk           (clk),
		.rst_n         (rst_n),
		.phase_i       (node_if.phase),
		.rd_pred_i     (rd_pred),
		.sink_cost_i   (sink_cost),
		.rd_node_o     (rd_node),
		.done_o        (done),
		.out_valid_o   (out_valid_o),
		.worst_delay_o (worst_delay_o),
		.path_o        (path_o)
	);

endmodule

// ==== sta_trace.sv ====
// --------------------
// STA backtrace
// Streams the critical path from output to input
// --------------------
`timescale 1ns/1ps

module sta_trace (
	input  logic            clk,
	input  logic            rst_n,
	input  sta_pkg::phase_e phase_i,
	input  sta_pkg::node_t  rd_pred_i,
	input  sta_pkg::cost_t  sink_cost_i,
	output sta_pkg::node_t  rd_node_o,
	output logic            done_o,
	output logic            out_valid_o,
	output sta_pkg::cost_t  worst_delay_o,
	output sta_pkg::node_t  path_o
);

	sta_pkg::node_t node_q;  // Node shown on the current beat
	logic           first_beat;

	// Walk one predecessor per cycle, park on the output node otherwise
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			node_q <= sta_pkg::SINK_NODE;
		end else if (phase_i == sta_pkg::PH_OUT) begin
			node_q <= rd_pred_i;
		end else begin
			node_q <= sta_pkg::SINK_NODE;
		end
	end

	assign out_valid_o = (phase_i == sta_pkg::PH_OUT);
	assign first_beat  = out_valid_o && (node_q == sta_pkg::SINK_NODE);

	assign rd_node_o     = node_q;
	assign done_o        = out_valid_o && (node_q == sta_pkg::SRC_NODE);
	assign path_o        = out_valid_o ? node_q : sta_pkg::SINK_NODE;
	assign worst_delay_o = first_beat ? sink_cost_i : '0;  // First beat only

endmodule

// ==== tb.f ====
sta_pkg.sv
sta_node_if.sv
sta_ctrl.sv
sta_graph.sv
sta_relax.sv
sta_trace.sv
sta_top.sv
tb_clkgen.sv
tb_sta.sv

// ==== tb_clkgen.sv ====
// --------------------
// Testbench clock and reset
// 4 ns clock, reset low for 4 cycles
// --------------------
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);  // Release away from the active edge
		rst_n = 1'b1;
	end

endmodule

// ==== tb_sta.sv ====
// --------------------
// STA testbench
// Directed netlists and random DAGs against a reference model
// --------------------
`timescale 1ns/1ps

module tb_sta;

	localparam int N        = sta_pkg::N_NODES;
	localparam int E        = sta_pkg::N_EDGES;
	localparam int SRC      = int'(sta_pkg::SRC_NODE);
	localparam int SINK     = int'(sta_pkg::SINK_NODE);
	localparam int WD_LIMIT = 30 * 100 * 4;  // Runs x cycles x ns
	localparam int WAIT_MAX = 100;

	logic            clk;
	logic            rst_n;
	logic            in_valid_i;
	sta_pkg::delay_t delay_i;
	sta_pkg::node_t  source_i;
	sta_pkg::node_t  destination_i;
	logic            out_valid_o;
	sta_pkg::cost_t  worst_delay_o;
	sta_pkg::node_t  path_o;

	sta_pkg::node_t  edge_src [E];
	sta_pkg::node_t  edge_dst [E];
	sta_pkg::delay_t gate_delay [N];
	int              n_used;
	int              exp_worst;
	int              exp_path [$];
	int              got_path [$];
	logic [31:0]     lcg_state = 32'ha93a;
	int              checks;
	int              errors;
	int              tests_run;
	int              tests_failed;

	tb_clkgen clkgen (.clk(clk), .rst_n(rst_n));

	sta_top uut (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid_i    (in_valid_i),
		.delay_i       (delay_i),
		.source_i      (source_i),
		.destination_i (destination_i),
		.out_valid_o   (out_valid_o),
		.worst_delay_o (worst_delay_o),
		.path_o        (path_o)
	);

	// LCG step, draw taken from the upper bits
	function automatic int rand_below(input int n);
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'(lcg_state[31:8] % 24'(n));
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	task automatic report_test(input string name, input int err0);
		tests_run++;
		if (errors != err0) begin
			tests_failed++;
		end
		$display("%-22s %s (%0d errors)", name, (errors == err0) ? "ok" : "FAILED", errors - err0);
	endtask

	// --------------------
	// Reference model
	// --------------------
	task automatic compute_expected();
		bit adj_m [N][N];
		bit visited_m [N];
		int arr_m [N];
		int pred_m [N];
		int s;
		int d;
		int sel;
		int cand;
		bit fanin;
		for (int u = 0; u < N; u++) begin
			for (int v = 0; v < N; v++) begin
				adj_m[u][v] = 1'b0;
			end
			visited_m[u] = 1'b0;
			arr_m[u]     = 0;
			pred_m[u]    = 0;
		end
		for (int k = 0; k < E; k++) begin
			s = int'(edge_src[k]);
			d = int'(edge_dst[k]);
			if (s != d && d != SRC && s != SINK) begin
				adj_m[s][d] = 1'b1;
			end
		end
		arr_m[SRC] = int'(gate_delay[SRC]);
		for (int step = 0; step < sta_pkg::CALC_CYCLES; step++) begin
			sel = -1;
			for (int c = 0; c < N; c++) begin
				fanin = 1'b0;
				for (int u = 0; u < N; u++) begin
					fanin = fanin | adj_m[u][c];
				end
				if (sel < 0 && !visited_m[c] && !fanin) begin
					sel = c;
				end
			end
			if (sel < 0) begin
				sel = N - 1;
			end
			for (int v = 0; v < N; v++) begin
				cand = (arr_m[sel] + int'(gate_delay[v])) % 256;
				if (adj_m[sel][v] && v != SRC && cand >= arr_m[v]) begin
					arr_m[v]  = cand;  // Later visit wins a tie
					pred_m[v] = sel;
				end
				adj_m[sel][v] = 1'b0;
			end
			visited_m[sel] = 1'b1;
		end
		exp_worst = arr_m[SINK];
		exp_path.delete();
		d = SINK;
		exp_path.push_back(d);
		while (d != SRC && exp_path.size() <= N) begin
			d = pred_m[d];
			exp_path.push_back(d);
		end
	endtask

	// Load one netlist, then collect and check the path stream
	task automatic run_netlist();
		int wait_cnt;
		int beat;
		compute_expected();
		for (int k = 0; k < E; k++) begin
			in_valid_i    = 1'b1;
			source_i      = edge_src[k];
			destination_i = edge_dst[k];
			delay_i       = (k < N) ? gate_delay[k] : '0;
			@(negedge clk);
		end
		in_valid_i    = 1'b0;
		source_i      = '0;
		destination_i = '0;
		delay_i       = '0;
		wait_cnt = 0;
		while (!out_valid_o && wait_cnt < WAIT_MAX) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (!out_valid_o) begin
			report_failure("out_valid_o never rose after the netlist was loaded");
			return;
		end
		// Rises on the 17th edge after the last load sample
		check_val("out_valid_o latency", 32'(wait_cnt), 32'd17);
		got_path.delete();
		beat = 0;
		while (out_valid_o && beat <= N) begin
			got_path.push_back(int'(path_o));
			check_val("worst_delay_o", 32'(worst_delay_o), (beat == 0) ? 32'(exp_worst) : 32'd0);
			beat++;
			@(negedge clk);
		end
		if (out_valid_o) begin
			report_failure("output stream ran longer than the node count");
		end
		check_val("path_o idle", 32'(path_o), 32'd0);
		check_val("worst_delay_o idle", 32'(worst_delay_o), 32'd0);
		check_val("path length", 32'(got_path.size()), 32'(exp_path.size()));
		for (int i = 0; i < got_path.size() && i < exp_path.size(); i++) begin
			check_val($sformatf("path_o beat %0d", i), 32'(got_path[i]), 32'(exp_path[i]));
		end
	endtask

	// --------------------
	// Netlist builders
	// --------------------
	task automatic clear_netlist(input int fill);
		n_used = 0;
		for (int v = 0; v < N; v++) begin
			gate_delay[v] = sta_pkg::delay_t'(fill + v);
		end
	endtask

	task automatic add_edge(input int s, input int d);
		edge_src[n_used] = sta_pkg::node_t'(s);
		edge_dst[n_used] = sta_pkg::node_t'(d);
		n_used++;
	endtask

	task automatic pad_edges();  // Repeat earlier edges up to 32
		for (int k = n_used; k < E; k++) begin
			edge_src[k] = edge_src[k % n_used];
			edge_dst[k] = edge_dst[k % n_used];
		end
		n_used = E;
	endtask

	task automatic build_random_dag();
		int order [N];
		int j;
		int tmp;
		int a;
		for (int i = 0; i < N - 1; i++) begin
			order[i] = i + 1;
		end
		order[N-1] = SINK;
		for (int i = N - 2; i >= 2; i--) begin
			j        = 1 + rand_below(i);
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		clear_netlist(0);
		for (int v = 0; v < N; v++) begin
			gate_delay[v] = sta_pkg::delay_t'(rand_below(16));
		end
		for (int p = 1; p < N; p++) begin
			add_edge(order[rand_below(p)], order[p]);  // Every node fed from earlier
		end
		while (n_used < E) begin
			a = rand_below(N - 1);
			add_edge(order[a], order[a + 1 + rand_below(N - 1 - a)]);
		end
	endtask

	// --------------------
	// Tests
	// --------------------
	task automatic chain_after_reset();
		int err0;
		err0 = errors;
		check_val("out_valid_o", 32'(out_valid_o), 32'd0);
		check_val("path_o", 32'(path_o), 32'd0);
		check_val("worst_delay_o", 32'(worst_delay_o), 32'd0);
		clear_netlist(1);
		add_edge(1, 2);
		add_edge(2, 3);
		add_edge(3, 4);
		add_edge(4, 5);
		add_edge(5, 0);
		pad_edges();
		run_netlist();
		check_val("model chain sum", 32'(exp_worst), 32'd21);  // Delays 2+3+4+5+6 plus node 0
		report_test("chain after reset", err0);
	endtask

	task automatic diamond_slow_branch();
		int err0;
		err0 = errors;
		clear_netlist(0);
		gate_delay[1] = 4'd2;
		gate_delay[2] = 4'd1;
		gate_delay[3] = 4'd6;
		gate_delay[5] = 4'd6;
		gate_delay[0] = 4'd3;
		add_edge(1, 2);
		add_edge(2, 0);
		add_edge(1, 3);
		add_edge(3, 5);
		add_edge(5, 0);
		add_edge(3, 3);  // Ignored edges
		add_edge(4, 1);
		add_edge(0, 2);
		add_edge(5, 1);
		pad_edges();
		run_netlist();
		check_val("model slow branch", 32'(exp_worst), 32'd17);  // 2+6+6+3 through nodes 3 and 5
		report_test("diamond slow branch", err0);
	endtask

	task automatic equal_branch_tie();
		int err0;
		err0 = errors;
		clear_netlist(0);
		gate_delay[1] = 4'd4;
		gate_delay[2] = 4'd5;
		gate_delay[3] = 4'd5;
		gate_delay[0] = 4'd2;
		add_edge(1, 2);
		add_edge(1, 3);
		add_edge(2, 0);
		add_edge(3, 0);
		pad_edges();
		run_netlist();
		check_val("model tie pred", 32'(exp_path[1]), 32'd3);
		report_test("equal branch tie", err0);
	endtask

	task automatic random_dags();
		int err0;
		err0 = errors;
		for (int r = 0; r < 20; r++) begin
			build_random_dag();
			run_netlist();
		end
		report_test("random DAGs", err0);
	endtask

	task automatic back_to_back();
		int err0;
		err0 = errors;
		build_random_dag();
		run_netlist();
		clear_netlist(0);
		gate_delay[1] = 4'd1;
		gate_delay[7] = 4'd1;
		gate_delay[0] = 4'd1;
		add_edge(1, 7);
		add_edge(7, 0);
		pad_edges();
		run_netlist();  // Starts the cycle after the previous stream ends
		report_test("back to back", err0);
	endtask

	initial begin
		#(WD_LIMIT);
		$display("Watchdog: run did not finish within %0d ns and was stopped", WD_LIMIT);
		$display("Test failures found");
		$finish;
	end

	initial begin
		in_valid_i    = 1'b0;
		delay_i       = '0;
		source_i      = '0;
		destination_i = '0;
		checks        = 0;
		errors        = 0;
		tests_run     = 0;
		tests_failed  = 0;
		@(posedge rst_n);
		@(negedge clk);
		chain_after_reset();
		diamond_slow_branch();
		equal_branch_tie();
		random_dags();
		back_to_back();
		$display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
		         tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
